// ==== rtl/l1_axi_pkg.sv ====
package l1_axi_pkg;

    // Default widths of the L1 memory port
    localparam int L1_ADDR_BITS = 48;
    localparam int L1_LINE_BITS = 256;

    // Request type from the L1 cache
    typedef logic [1:0] req_type_t;
    localparam int REQ_TYPE_WRITE  = 0;         // 0 = read, 1 = write
    localparam int REQ_TYPE_CACHED = 1;         // 0 = device, 1 = cached

    typedef logic [2:0] axi_size_t;             // Bytes per beat is 2**size

    // AxCACHE encodings
    typedef logic [3:0] axi_cache_t;
    localparam axi_cache_t CACHE_RD_WRBACK_ALLOC = 4'b1111;
    localparam axi_cache_t CACHE_RD_DEVICE       = 4'b0000;
    localparam axi_cache_t CACHE_WR_WRBACK_ALLOC = 4'b1111;
    localparam axi_cache_t CACHE_WR_DEVICE       = 4'b0000;

    // AxPROT layout
    //   [2] 0 = data, 1 = instruction
    //   [1] 0 = secure
    //   [0] 0 = unprivileged
    typedef logic [2:0] axi_prot_t;

    // RRESP/BRESP code with bit 1 set for SLVERR and DECERR
    typedef logic [1:0] axi_resp_t;
    localparam int RESP_ERR_BIT = 1;

    // AXI channel sequencer states
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_AR,
        SEQ_R,
        SEQ_AW,
        SEQ_W,
        SEQ_B
    } seq_state_t;

endpackage

// ==== rtl/l1_req_decode.sv ====
`timescale 1ns/1ps

module l1_req_decode #(
    parameter int ADDR_W = l1_axi_pkg::L1_ADDR_BITS,
    parameter int LINE_W = l1_axi_pkg::L1_LINE_BITS
) (
    input  logic                   i_clk,
    input  logic                   i_nrst,
    input  logic                   i_accept,        // Request taken this cycle
    input  l1_axi_pkg::req_type_t  i_req_type,
    input  logic                   i_req_path,      // 1 = instruction fetch
    input  l1_axi_pkg::axi_size_t  i_req_size,
    input  logic [ADDR_W-1:0]      i_req_addr,
    input  logic [LINE_W/8-1:0]    i_req_strob,
    input  logic [LINE_W-1:0]      i_req_data,
    output logic                   o_dec_write,
    output logic [ADDR_W-1:0]      o_addr,
    output l1_axi_pkg::axi_size_t  o_size,
    output l1_axi_pkg::axi_cache_t o_cache,
    output l1_axi_pkg::axi_prot_t  o_prot,
    output logic [LINE_W-1:0]      o_wdata,
    output logic [LINE_W/8-1:0]    o_wstrb
);
    import l1_axi_pkg::*;

    logic       is_write;
    logic       is_cached;
    axi_cache_t cache_code;
    axi_prot_t  prot_code;

    assign is_write  = i_req_type[REQ_TYPE_WRITE];
    assign is_cached = i_req_type[REQ_TYPE_CACHED];

    // Sequencer branches on this before the capture
    assign o_dec_write = is_write;

    // Read and write use separate AxCACHE tables
    always_comb begin
        if (is_write) begin
            cache_code = is_cached ? CACHE_WR_WRBACK_ALLOC : CACHE_WR_DEVICE;
        end else begin
            cache_code = is_cached ? CACHE_RD_WRBACK_ALLOC : CACHE_RD_DEVICE;
        end
    end

    assign prot_code = {i_req_path, 2'b00};     // Secure, unprivileged

    // Attribute registers
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_size  <= '0;
            o_cache <= CACHE_RD_DEVICE;
            o_prot  <= '0;
        end else if (i_accept) begin
            o_size  <= i_req_size;
            o_cache <= cache_code;
            o_prot  <= prot_code;
        end
    end

    // Address and line payload
    always_ff @(posedge i_clk) begin
        if (i_accept) begin
            o_addr <= i_req_addr;
            if (is_write) begin
                o_wdata <= i_req_data;
                o_wstrb <= i_req_strob;
            end else begin
                o_wdata <= '0;                  // Nothing to write on a read
                o_wstrb <= '0;
            end
        end
    end

endmodule

// ==== rtl/axi_channel_seq.sv ====
`timescale 1ns/1ps

module axi_channel_seq (
    input  logic i_clk,
    input  logic i_nrst,
    input  logic i_req_valid,
    input  logic i_dec_write,       // Decoded write bit of the pending request
    input  logic i_ar_ready,
    input  logic i_aw_ready,
    input  logic i_w_ready,
    input  logic i_done,            // Response handshake completed
    output logic o_req_ready,
    output logic o_accept,
    output logic o_ar_valid,
    output logic o_aw_valid,
    output logic o_w_valid,
    output logic o_r_phase,
    output logic o_b_phase
);
    import l1_axi_pkg::*;

    seq_state_t state_q;
    seq_state_t state_d;
    logic       w_sent_q;           // W beat already taken while AW waits
    logic       w_sent_d;
    logic       w_hs;

    // Ready only in idle since one request runs at a time
    assign o_req_ready = (state_q == SEQ_IDLE);
    assign o_accept    = o_req_ready & i_req_valid;

    assign o_ar_valid = (state_q == SEQ_AR);
    assign o_aw_valid = (state_q == SEQ_AW);

    // W rides along with AW unless the slave took it early
    assign o_w_valid = ((state_q == SEQ_AW) & ~w_sent_q) | (state_q == SEQ_W);
    assign w_hs      = o_w_valid & i_w_ready;

    assign o_r_phase = (state_q == SEQ_R);
    assign o_b_phase = (state_q == SEQ_B);

    always_comb begin
        state_d  = state_q;
        w_sent_d = w_sent_q;
        case (state_q)
            SEQ_IDLE: begin
                w_sent_d = 1'b0;
                if (o_accept) begin
                    if (i_dec_write) begin
                        state_d = SEQ_AW;
                    end else begin
                        state_d = SEQ_AR;
                    end
                end
            end
            SEQ_AR: begin
                if (i_ar_ready) begin
                    state_d = SEQ_R;
                end
            end
            SEQ_R: begin
                if (i_done) begin
                    state_d = SEQ_IDLE;
                end
            end
            SEQ_AW: begin
                if (i_aw_ready) begin
                    // W taken now or before means only B is left
                    if (w_hs || w_sent_q) begin
                        state_d = SEQ_B;
                    end else begin
                        state_d = SEQ_W;    // AW went alone
                    end
                end else if (w_hs) begin
                    w_sent_d = 1'b1;
                end
            end
            SEQ_W: begin
                if (i_w_ready) begin
                    state_d = SEQ_B;
                end
            end
            SEQ_B: begin
                if (i_done) begin
                    state_d = SEQ_IDLE;
                end
            end
            default: begin
                state_d = SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q  <= SEQ_IDLE;
            w_sent_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            w_sent_q <= w_sent_d;
        end
    end

endmodule

// ==== rtl/l1_resp_collect.sv ====
`timescale 1ns/1ps

module l1_resp_collect #(
    parameter int LINE_W = l1_axi_pkg::L1_LINE_BITS
) (
    input  logic                  i_clk,
    input  logic                  i_nrst,
    input  logic                  i_accept,
    input  logic                  i_req_path,
    input  logic                  i_r_phase,        // Sequencer waits for R
    input  logic                  i_b_phase,        // Sequencer waits for B
    input  logic                  i_r_valid,
    input  logic                  i_r_last,
    input  l1_axi_pkg::axi_resp_t i_r_resp,
    input  logic [LINE_W-1:0]     i_r_data,
    input  logic                  i_b_valid,
    input  l1_axi_pkg::axi_resp_t i_b_resp,
    output logic                  o_r_ready,
    output logic                  o_b_ready,
    output logic                  o_done,
    output logic                  o_resp_valid,
    output logic                  o_resp_path,
    output logic [LINE_W-1:0]     o_resp_data,
    output logic                  o_resp_load_fault,
    output logic                  o_resp_store_fault
);
    import l1_axi_pkg::*;

    logic path_q;
    logic r_done;
    logic b_done;

    // Path of the request in flight
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            path_q <= 1'b0;
        end else if (i_accept) begin
            path_q <= i_req_path;
        end
    end

    assign o_r_ready = i_r_phase;
    assign o_b_ready = i_b_phase;

    // The beat with last ends the single-beat read
    assign r_done = i_r_phase & i_r_valid & i_r_last;
    assign b_done = i_b_phase & i_b_valid;

    assign o_done       = r_done | b_done;
    assign o_resp_valid = o_done;                   // No back-pressure toward L1
    assign o_resp_path  = path_q;
    assign o_resp_data  = i_r_data;

    assign o_resp_load_fault  = r_done & i_r_resp[RESP_ERR_BIT];
    assign o_resp_store_fault = b_done & i_b_resp[RESP_ERR_BIT];

endmodule

// ==== rtl/l1_axi_bridge.sv ====
`timescale 1ns/1ps

module l1_axi_bridge #(
    parameter int ADDR_W = l1_axi_pkg::L1_ADDR_BITS,
    parameter int LINE_W = l1_axi_pkg::L1_LINE_BITS
) (
    input  logic                   i_clk,
    input  logic                   i_nrst,
    // L1 request
    input  logic                   i_req_valid,
    input  logic                   i_req_path,
    input  l1_axi_pkg::req_type_t  i_req_type,
    input  l1_axi_pkg::axi_size_t  i_req_size,
    input  logic [ADDR_W-1:0]      i_req_addr,
    input  logic [LINE_W/8-1:0]    i_req_strob,
    input  logic [LINE_W-1:0]      i_req_data,
    output logic                   o_req_ready,
    // L1 response
    output logic                   o_resp_valid,
    output logic                   o_resp_path,
    output logic [LINE_W-1:0]      o_resp_data,
    output logic                   o_resp_load_fault,
    output logic                   o_resp_store_fault,
    // AR channel
    output logic                   o_ar_valid,
    input  logic                   i_ar_ready,
    output logic [ADDR_W-1:0]      o_ar_addr,
    output l1_axi_pkg::axi_size_t  o_ar_size,
    output l1_axi_pkg::axi_cache_t o_ar_cache,
    output l1_axi_pkg::axi_prot_t  o_ar_prot,
    // R channel
    input  logic                   i_r_valid,
    output logic                   o_r_ready,
    input  logic [LINE_W-1:0]      i_r_data,
    input  l1_axi_pkg::axi_resp_t  i_r_resp,
    input  logic                   i_r_last,
    // AW channel
    output logic                   o_aw_valid,
    input  logic                   i_aw_ready,
    output logic [ADDR_W-1:0]      o_aw_addr,
    output l1_axi_pkg::axi_size_t  o_aw_size,
    output l1_axi_pkg::axi_cache_t o_aw_cache,
    output l1_axi_pkg::axi_prot_t  o_aw_prot,
    // W channel
    output logic                   o_w_valid,
    input  logic                   i_w_ready,
    output logic [LINE_W-1:0]      o_w_data,
    output logic [LINE_W/8-1:0]    o_w_strb,
    // B channel
    input  logic                   i_b_valid,
    output logic                   o_b_ready,
    input  l1_axi_pkg::axi_resp_t  i_b_resp
);
    import l1_axi_pkg::*;

    logic              accept;
    logic              dec_write;
    logic              r_phase;
    logic              b_phase;
    logic              done;
    logic [ADDR_W-1:0] req_addr;
    axi_size_t         req_size;
    axi_cache_t        req_cache;
    axi_prot_t         req_prot;

    l1_req_decode #(
        .ADDR_W(ADDR_W),
        .LINE_W(LINE_W)
    ) u_decode (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_accept    (accept),
        .i_req_type  (i_req_type),
        .i_req_path  (i_req_path),
        .i_req_size  (i_req_size),
        .i_req_addr  (i_req_addr),
        .i_req_strob (i_req_strob),
        .i_req_data  (i_req_data),
        .o_dec_write (dec_write),
        .o_addr      (req_addr),
        .o_size      (req_size),
        .o_cache     (req_cache),
        .o_prot      (req_prot),
        .o_wdata     (o_w_data),
        .o_wstrb     (o_w_strb)
    );

    axi_channel_seq u_seq (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_req_valid (i_req_valid),
        .i_dec_write (dec_write),
        .i_ar_ready  (i_ar_ready),
        .i_aw_ready  (i_aw_ready),
        .i_w_ready   (i_w_ready),
        .i_done      (done),
        .o_req_ready (o_req_ready),
        .o_accept    (accept),
        .o_ar_valid  (o_ar_valid),
        .o_aw_valid  (o_aw_valid),
        .o_w_valid   (o_w_valid),
        .o_r_phase   (r_phase),
        .o_b_phase   (b_phase)
    );

    l1_resp_collect #(
        .LINE_W(LINE_W)
    ) u_resp (
        .i_clk              (i_clk),
        .i_nrst             (i_nrst),
        .i_accept           (accept),
        .i_req_path         (i_req_path),
        .i_r_phase          (r_phase),
        .i_b_phase          (b_phase),
        .i_r_valid          (i_r_valid),
        .i_r_last           (i_r_last),
        .i_r_resp           (i_r_resp),
        .i_r_data           (i_r_data),
        .i_b_valid          (i_b_valid),
        .i_b_resp           (i_b_resp),
        .o_r_ready          (o_r_ready),
        .o_b_ready          (o_b_ready),
        .o_done             (done),
        .o_resp_valid       (o_resp_valid),
        .o_resp_path        (o_resp_path),
        .o_resp_data        (o_resp_data),
        .o_resp_load_fault  (o_resp_load_fault),
        .o_resp_store_fault (o_resp_store_fault)
    );

    // Both address channels read the same capture registers
    assign o_ar_addr  = req_addr;
    assign o_ar_size  = req_size;
    assign o_ar_cache = req_cache;
    assign o_ar_prot  = req_prot;
    assign o_aw_addr  = req_addr;
    assign o_aw_size  = req_size;
    assign o_aw_cache = req_cache;
    assign o_aw_prot  = req_prot;

endmodule

// ==== test/axi_slave_model.sv ====
`timescale 1ns/1ps

module axi_slave_model #(
    parameter int ADDR_W = 48,
    parameter int LINE_W = 256
) (
    input  logic                i_clk,
    input  logic                i_nrst,
    input  logic [1:0]          i_cfg_resp,     // Code for the next R or B
    input  logic [LINE_W-1:0]   i_cfg_rdata,
    input  logic                i_ar_valid,
    input  logic [ADDR_W-1:0]   i_ar_addr,
    input  logic [2:0]          i_ar_size,
    input  logic [3:0]          i_ar_cache,
    input  logic [2:0]          i_ar_prot,
    input  logic                i_aw_valid,
    input  logic [ADDR_W-1:0]   i_aw_addr,
    input  logic [2:0]          i_aw_size,
    input  logic [3:0]          i_aw_cache,
    input  logic [2:0]          i_aw_prot,
    input  logic                i_w_valid,
    input  logic [LINE_W-1:0]   i_w_data,
    input  logic [LINE_W/8-1:0] i_w_strb,
    input  logic                i_r_ready,
    input  logic                i_b_ready,
    output logic                o_ar_ready,
    output logic                o_aw_ready,
    output logic                o_w_ready,
    output logic                o_r_valid,
    output logic [LINE_W-1:0]   o_r_data,
    output logic [1:0]          o_r_resp,
    output logic                o_r_last,
    output logic                o_b_valid,
    output logic [1:0]          o_b_resp,
    output logic [ADDR_W-1:0]   o_rec_ar_addr,
    output logic [2:0]          o_rec_ar_size,
    output logic [3:0]          o_rec_ar_cache,
    output logic [2:0]          o_rec_ar_prot,
    output logic [ADDR_W-1:0]   o_rec_aw_addr,
    output logic [2:0]          o_rec_aw_size,
    output logic [3:0]          o_rec_aw_cache,
    output logic [2:0]          o_rec_aw_prot,
    output logic [LINE_W-1:0]   o_rec_w_data,
    output logic [LINE_W/8-1:0] o_rec_w_strb,
    output int                  o_ar_count,
    output int                  o_aw_count,
    output int                  o_w_count
);
    logic [7:0] rnd;                // Fresh delay bits for every channel
    logic [1:0] ar_wait;
    logic [1:0] aw_wait;
    logic [1:0] w_wait;
    logic [1:0] r_wait;
    logic [1:0] b_wait;
    logic       r_pend;
    logic       aw_got;
    logic       w_got;

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $urandom;
        return r[7:0];
    endfunction

    assign o_r_last = 1'b1;         // Single beat only

    always @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            rnd <= '0;
            {o_ar_ready, o_aw_ready, o_w_ready, o_r_valid, o_b_valid} <= '0;
            {ar_wait, aw_wait, w_wait, r_wait, b_wait} <= '0;
            {r_pend, aw_got, w_got} <= '0;
            o_r_data <= '0;
            o_r_resp <= '0;
            o_b_resp <= '0;
            o_ar_count <= 0;
            o_aw_count <= 0;
            o_w_count <= 0;
        end else begin
            rnd <= rand_byte();
            // Ready on AR may already be up when valid arrives
            if (i_ar_valid && o_ar_ready) begin
                o_ar_ready     <= (rnd[1:0] == 2'd0);
                ar_wait        <= rnd[1:0];
                o_ar_count     <= o_ar_count + 1;
                o_rec_ar_addr  <= i_ar_addr;
                o_rec_ar_size  <= i_ar_size;
                o_rec_ar_cache <= i_ar_cache;
                o_rec_ar_prot  <= i_ar_prot;
                r_pend         <= 1'b1;
                r_wait         <= rnd[7:6];
            end else if (i_ar_valid) begin
                if (ar_wait == 2'd0) o_ar_ready <= 1'b1;
                else ar_wait <= ar_wait - 2'd1;
            end
            // R beat after a random gap
            if (o_r_valid && i_r_ready) begin
                o_r_valid <= 1'b0;
            end else if (r_pend) begin
                if (r_wait == 2'd0) begin
                    o_r_valid <= 1'b1;
                    o_r_data  <= i_cfg_rdata;
                    o_r_resp  <= i_cfg_resp;
                    r_pend    <= 1'b0;
                end else begin
                    r_wait <= r_wait - 2'd1;
                end
            end
            // AW channel
            if (i_aw_valid && o_aw_ready) begin
                o_aw_ready     <= (rnd[3:2] == 2'd0);
                aw_wait        <= rnd[3:2];
                o_aw_count     <= o_aw_count + 1;
                o_rec_aw_addr  <= i_aw_addr;
                o_rec_aw_size  <= i_aw_size;
                o_rec_aw_cache <= i_aw_cache;
                o_rec_aw_prot  <= i_aw_prot;
                aw_got         <= 1'b1;
            end else if (i_aw_valid) begin
                if (aw_wait == 2'd0) o_aw_ready <= 1'b1;
                else aw_wait <= aw_wait - 2'd1;
            end
            // W runs independent of AW so it can lag or lead
            if (i_w_valid && o_w_ready) begin
                o_w_ready    <= (rnd[5:4] == 2'd0);
                w_wait       <= rnd[5:4];
                o_w_count    <= o_w_count + 1;
                o_rec_w_data <= i_w_data;
                o_rec_w_strb <= i_w_strb;
                w_got        <= 1'b1;
                b_wait       <= rnd[7:6];
            end else if (i_w_valid) begin
                if (w_wait == 2'd0) o_w_ready <= 1'b1;
                else w_wait <= w_wait - 2'd1;
            end
            // B once both AW and W are in
            if (o_b_valid && i_b_ready) begin
                o_b_valid <= 1'b0;
            end else if (aw_got && w_got && !o_b_valid) begin
                if (b_wait == 2'd0) begin
                    o_b_valid <= 1'b1;
                    o_b_resp  <= i_cfg_resp;
                    aw_got    <= 1'b0;
                    w_got     <= 1'b0;
                end else begin
                    b_wait <= b_wait - 2'd1;
                end
            end
        end
    end

endmodule

// ==== test/tb_l1_axi_bridge.sv ====
`timescale 1ns/1ps

module tb_l1_axi_bridge;
    localparam int ADDR_W  = 48;
    localparam int LINE_W  = 256;
    localparam int N_TESTS = 9;
    localparam int LIMIT   = 40 * N_TESTS + 20;

    typedef struct {
        logic                write;
        logic                cached;
        logic                path;
        logic [2:0]          size;
        logic [ADDR_W-1:0]   addr;
        logic [LINE_W-1:0]   wdata;
        logic [LINE_W/8-1:0] strb;
        logic [1:0]          resp;
        logic [LINE_W-1:0]   rdata;
        logic [3:0]          exp_cache;
        logic [2:0]          exp_prot;
        logic                exp_fault;
    } test_entry_t;

    test_entry_t tbl [N_TESTS];

    logic i_clk, i_nrst, i_req_valid, i_req_path;
    logic [1:0] i_req_type, cfg_resp, r_resp, b_resp;
    logic [2:0] i_req_size, ar_size, aw_size, ar_prot, aw_prot;
    logic [ADDR_W-1:0] i_req_addr, ar_addr, aw_addr;
    logic [LINE_W/8-1:0] i_req_strob, w_strb;
    logic [LINE_W-1:0] i_req_data, cfg_rdata, r_data, w_data, o_resp_data;
    logic o_req_ready, o_resp_valid, o_resp_path, o_resp_load_fault, o_resp_store_fault;
    logic ar_valid, ar_ready, aw_valid, aw_ready, w_valid, w_ready;
    logic r_valid, r_ready, r_last, b_valid, b_ready;
    logic [3:0] ar_cache, aw_cache;
    logic [ADDR_W-1:0] rec_ar_addr, rec_aw_addr;
    logic [2:0] rec_ar_size, rec_aw_size, rec_ar_prot, rec_aw_prot;
    logic [3:0] rec_ar_cache, rec_aw_cache;
    logic [LINE_W-1:0] rec_w_data;
    logic [LINE_W/8-1:0] rec_w_strb;
    int ar_count, aw_count, w_count;

    int errors = 0;
    int pass_count = 0;
    int fail_count = 0;
    int resp_count = 0;
    int cycles = 0;
    logic busy = 1'b0;
    logic ar_hold = 1'b0, aw_hold = 1'b0, w_hold = 1'b0;
    logic [ADDR_W+9:0] ar_pay, aw_pay, ar_pay_prev, aw_pay_prev;
    logic [LINE_W+LINE_W/8-1:0] w_pay, w_pay_prev;

    // Whole payload of each channel
    assign ar_pay = {ar_addr, ar_size, ar_cache, ar_prot};
    assign aw_pay = {aw_addr, aw_size, aw_cache, aw_prot};
    assign w_pay  = {w_data, w_strb};

    l1_axi_bridge #(.ADDR_W(ADDR_W), .LINE_W(LINE_W)) i_dut (
        .i_clk(i_clk), .i_nrst(i_nrst),
        .i_req_valid(i_req_valid), .i_req_path(i_req_path), .i_req_type(i_req_type),
        .i_req_size(i_req_size), .i_req_addr(i_req_addr), .i_req_strob(i_req_strob),
        .i_req_data(i_req_data), .o_req_ready(o_req_ready),
        .o_resp_valid(o_resp_valid), .o_resp_path(o_resp_path), .o_resp_data(o_resp_data),
        .o_resp_load_fault(o_resp_load_fault), .o_resp_store_fault(o_resp_store_fault),
        .o_ar_valid(ar_valid), .i_ar_ready(ar_ready), .o_ar_addr(ar_addr),
        .o_ar_size(ar_size), .o_ar_cache(ar_cache), .o_ar_prot(ar_prot),
        .i_r_valid(r_valid), .o_r_ready(r_ready), .i_r_data(r_data),
        .i_r_resp(r_resp), .i_r_last(r_last),
        .o_aw_valid(aw_valid), .i_aw_ready(aw_ready), .o_aw_addr(aw_addr),
        .o_aw_size(aw_size), .o_aw_cache(aw_cache), .o_aw_prot(aw_prot),
        .o_w_valid(w_valid), .i_w_ready(w_ready), .o_w_data(w_data), .o_w_strb(w_strb),
        .i_b_valid(b_valid), .o_b_ready(b_ready), .i_b_resp(b_resp)
    );

    axi_slave_model #(.ADDR_W(ADDR_W), .LINE_W(LINE_W)) i_slave (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_cfg_resp(cfg_resp), .i_cfg_rdata(cfg_rdata),
        .i_ar_valid(ar_valid), .i_ar_addr(ar_addr), .i_ar_size(ar_size),
        .i_ar_cache(ar_cache), .i_ar_prot(ar_prot),
        .i_aw_valid(aw_valid), .i_aw_addr(aw_addr), .i_aw_size(aw_size),
        .i_aw_cache(aw_cache), .i_aw_prot(aw_prot),
        .i_w_valid(w_valid), .i_w_data(w_data), .i_w_strb(w_strb),
        .i_r_ready(r_ready), .i_b_ready(b_ready),
        .o_ar_ready(ar_ready), .o_aw_ready(aw_ready), .o_w_ready(w_ready),
        .o_r_valid(r_valid), .o_r_data(r_data), .o_r_resp(r_resp), .o_r_last(r_last),
        .o_b_valid(b_valid), .o_b_resp(b_resp),
        .o_rec_ar_addr(rec_ar_addr), .o_rec_ar_size(rec_ar_size),
        .o_rec_ar_cache(rec_ar_cache), .o_rec_ar_prot(rec_ar_prot),
        .o_rec_aw_addr(rec_aw_addr), .o_rec_aw_size(rec_aw_size),
        .o_rec_aw_cache(rec_aw_cache), .o_rec_aw_prot(rec_aw_prot),
        .o_rec_w_data(rec_w_data), .o_rec_w_strb(rec_w_strb),
        .o_ar_count(ar_count), .o_aw_count(aw_count), .o_w_count(w_count)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    function automatic logic [LINE_W-1:0] rand_line();
        return {$urandom, $urandom, $urandom, $urandom,
                $urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic add_entry(input int idx, input logic wr, input logic cached,
                             input logic path, input logic [2:0] size,
                             input logic [ADDR_W-1:0] addr, input logic [1:0] resp,
                             input logic [3:0] exp_cache, input logic [2:0] exp_prot,
                             input logic exp_fault);
        tbl[idx].write     = wr;
        tbl[idx].cached    = cached;
        tbl[idx].path      = path;
        tbl[idx].size      = size;
        tbl[idx].addr      = addr;
        tbl[idx].wdata     = rand_line();
        tbl[idx].strb      = $urandom;
        tbl[idx].resp      = resp;
        tbl[idx].rdata     = rand_line();
        tbl[idx].exp_cache = exp_cache;
        tbl[idx].exp_prot  = exp_prot;
        tbl[idx].exp_fault = exp_fault;
    endtask

    // Cycle limit
    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Request/response ordering and payload stability
    always @(posedge i_clk) begin
        if (i_nrst) begin
            if (busy && o_req_ready) report_mismatch("o_req_ready high while busy");
            if (o_resp_valid && !busy) report_mismatch("response without a request");
            if (ar_hold && (!ar_valid || ar_pay != ar_pay_prev))
                report_mismatch("AR dropped or changed before ready");
            if (aw_hold && (!aw_valid || aw_pay != aw_pay_prev))
                report_mismatch("AW dropped or changed before ready");
            if (w_hold && (!w_valid || w_pay != w_pay_prev))
                report_mismatch("W dropped or changed before ready");
            if (i_req_valid && o_req_ready) busy <= 1'b1;
            if (o_resp_valid) begin
                busy <= 1'b0;
                resp_count <= resp_count + 1;
            end
        end
        ar_hold     <= ar_valid && !ar_ready;
        aw_hold     <= aw_valid && !aw_ready;
        w_hold      <= w_valid && !w_ready;
        ar_pay_prev <= ar_pay;
        aw_pay_prev <= aw_pay;
        w_pay_prev  <= w_pay;
    end

    task automatic run_entry(input int t);
        test_entry_t e;
        int ar0, aw0, w0, resp0, err0;
        logic got_path, got_load, got_store;
        logic [LINE_W-1:0] got_data;
        e = tbl[t];
        ar0 = ar_count;
        aw0 = aw_count;
        w0 = w_count;
        resp0 = resp_count;
        err0 = errors;
        @(posedge i_clk);
        i_req_valid <= 1'b1;
        i_req_type[l1_axi_pkg::REQ_TYPE_WRITE]  <= e.write;
        i_req_type[l1_axi_pkg::REQ_TYPE_CACHED] <= e.cached;
        i_req_path  <= e.path;
        i_req_size  <= e.size;
        i_req_addr  <= e.addr;
        i_req_data  <= e.wdata;
        i_req_strob <= e.strb;
        cfg_resp    <= e.resp;
        cfg_rdata   <= e.rdata;
        do @(posedge i_clk); while (!o_req_ready);
        i_req_valid <= 1'b0;
        do @(posedge i_clk); while (!o_resp_valid);
        got_path  = o_resp_path;
        got_data  = o_resp_data;
        got_load  = o_resp_load_fault;
        got_store = o_resp_store_fault;
        @(posedge i_clk);               // Let slave counters settle
        if (!o_req_ready) report_mismatch("bridge not idle after response");
        if (resp_count - resp0 != 1) report_mismatch("response count not one");
        if (got_path != e.path) report_mismatch("response path");
        if (e.write) begin
            if (aw_count - aw0 != 1 || w_count - w0 != 1 || ar_count != ar0)
                report_mismatch("write handshake counts");
            if (rec_aw_addr != e.addr || rec_aw_size != e.size) report_mismatch("AW addr/size");
            if (rec_aw_cache != e.exp_cache) report_mismatch("AW cache");
            if (rec_aw_prot != e.exp_prot) report_mismatch("AW prot");
            if (rec_w_data != e.wdata || rec_w_strb != e.strb) report_mismatch("W data/strb");
            if (got_store != e.exp_fault || got_load) report_mismatch("write fault flags");
        end else begin
            if (ar_count - ar0 != 1 || aw_count != aw0 || w_count != w0)
                report_mismatch("read handshake counts");
            if (rec_ar_addr != e.addr || rec_ar_size != e.size) report_mismatch("AR addr/size");
            if (rec_ar_cache != e.exp_cache) report_mismatch("AR cache");
            if (rec_ar_prot != e.exp_prot) report_mismatch("AR prot");
            if (got_data != e.rdata) report_mismatch("read data");
            if (got_load != e.exp_fault || got_store) report_mismatch("read fault flags");
        end
        if (errors == err0) pass_count++;
        else fail_count++;
        $display("test %0d %s resp=%0d: %s", t, e.write ? "write" : "read", e.resp,
                 errors == err0 ? "ok" : "mismatch");
    endtask

    initial begin
        int err0;
        void'($urandom(32'h36d2c6f3));
        i_nrst <= 1'b0;
        i_req_valid <= 1'b0;
        i_req_path <= 1'b0;
        i_req_type <= '0;
        i_req_size <= '0;
        i_req_addr <= '0;
        i_req_strob <= '0;
        i_req_data <= '0;
        cfg_resp <= '0;
        cfg_rdata <= '0;
        // Type bits are write, cached; prot[2] follows the path
        add_entry(0, 1'b0, 1'b1, 1'b0, 3'd3, 48'h0000_1000_0040, 2'b00, 4'b1111, 3'b000, 1'b0);
        add_entry(1, 1'b0, 1'b0, 1'b1, 3'd2, 48'h0000_2000_0004, 2'b00, 4'b0000, 3'b100, 1'b0);
        add_entry(2, 1'b1, 1'b1, 1'b0, 3'd5, 48'h0000_3000_0000, 2'b00, 4'b1111, 3'b000, 1'b0);
        add_entry(3, 1'b1, 1'b0, 1'b0, 3'd2, 48'h0000_4000_0008, 2'b01, 4'b0000, 3'b000, 1'b0);
        add_entry(4, 1'b0, 1'b1, 1'b0, 3'd5, 48'h7fff_0000_0020, 2'b10, 4'b1111, 3'b000, 1'b1);
        add_entry(5, 1'b1, 1'b0, 1'b1, 3'd3, 48'h0012_3456_7890, 2'b11, 4'b0000, 3'b100, 1'b1);
        add_entry(6, 1'b0, 1'b1, 1'b1, 3'd5, 48'hffff_ffff_ffe0, 2'b11, 4'b1111, 3'b100, 1'b1);
        add_entry(7, 1'b1, 1'b1, 1'b1, 3'd5, 48'h0000_0000_0000, 2'b10, 4'b1111, 3'b100, 1'b1);
        add_entry(8, 1'b0, 1'b0, 1'b0, 3'd0, 48'h0000_5000_0001, 2'b01, 4'b0000, 3'b000, 1'b0);
        repeat (2) @(posedge i_clk);
        i_nrst <= 1'b1;
        @(posedge i_clk);
        @(posedge i_clk);
        err0 = errors;
        if (!o_req_ready) report_mismatch("o_req_ready low after reset");
        if (ar_valid || aw_valid || w_valid || r_ready || b_ready || o_resp_valid)
            report_mismatch("AXI valid or ready active after reset");
        if (errors == err0) pass_count++;
        else fail_count++;
        $display("reset check: %s", errors == err0 ? "ok" : "mismatch");
        for (int t = 0; t < N_TESTS; t++) begin
            run_entry(t);
        end
        $display("Summary: %0d passed, %0d failed, %0d errors", pass_count, fail_count, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
rtl/l1_axi_pkg.sv
rtl/l1_req_decode.sv
rtl/axi_channel_seq.sv
rtl/l1_resp_collect.sv
rtl/l1_axi_bridge.sv
test/axi_slave_model.sv
test/tb_l1_axi_bridge.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --top-module tb_l1_axi_bridge -f src.f -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat build.log; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0
